/* Bender.yml */
package:
  name: lg_top

sources:
  - include_dirs:
      - include
    files:
      - rtl/lg_pkg.sv
      - rtl/lg_stream_if.sv
      - rtl/lg_regs.sv
      - rtl/lg_table.sv
      - rtl/lg_burst_seq.sv
      - rtl/lg_out_mask.sv
      - rtl/lg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_lg_top.sv

/* include/lg_params.svh */
// widths, depths and register map of the logic generator
// included by the package, the RTL and the testbench
`ifndef LG_PARAMS_SVH
`define LG_PARAMS_SVH

`define LG_DW          8     // sample width
`define LG_TBL_AW      8     // table address width, 256 entries
`define LG_CW          16    // burst counters
`define LG_SEQ_CREDITS 4     // output FIFO depth, power of 2
`define LG_EXT_CREDITS 2     // credits granted by the pin consumer
`define LG_BAW         12    // bus address width
`define LG_BUS_DW      32    // bus data width
`define LG_TBL_BIT     11    // table window select

// register offsets, 4 byte stride
`define LG_REG_CTL  'h00
`define LG_REG_TRG  'h08
`define LG_REG_MODE 'h10
`define LG_REG_BDR  'h20
`define LG_REG_BDL  'h24
`define LG_REG_BPL  'h28
`define LG_REG_BPN  'h2c
`define LG_REG_SBPL 'h30
`define LG_REG_SBPN 'h34
`define LG_REG_OE0  'h40
`define LG_REG_OE1  'h44
`define LG_REG_MSK  'h48
`define LG_REG_VAL  'h4c

`endif

/* lg_top.f */
+incdir+include
rtl/lg_pkg.sv
rtl/lg_stream_if.sv
rtl/lg_regs.sv
rtl/lg_table.sv
rtl/lg_burst_seq.sv
rtl/lg_out_mask.sv
rtl/lg_top.sv
verification/tb_lg_top.sv

/* rtl/lg_burst_seq.sv */
// burst sequencer, walks the table with repetitions, pads each period
// with zeros and repeats periods, sends samples while credits last
// bdl and bpl are expected to be nonzero
`timescale 1ns/10ps
`default_nettype none

`include "lg_params.svh"

module lg_burst_seq
  import lg_pkg::*;
(
  input  logic                  bus,
  input  logic                  arst_n,
  input  lg_cfg_t               cfg,
  input  evn_t                  evn,
  input  logic                  trg,
  output evn_t                  sts,
  output logic [`LG_CW-1:0]     sts_bpl,
  output logic [`LG_CW-1:0]     sts_bpn,
  output logic [`LG_TBL_AW-1:0] rd_addr,
  input  sample_t               rd_data,
  lg_stream_if.src              str
);

  localparam int CW  = `LG_CW;
  localparam int CCW = $clog2(`LG_SEQ_CREDITS + 1);

  typedef enum logic [1:0] {IDLE, DATA, PAD} state_t;

  state_t                state;
  logic [`LG_TBL_AW-1:0] adr;      // table address
  logic [CW-1:0]         rep;      // repetitions of current entry
  logic [CW-1:0]         cnt_bpl;  // samples issued in period
  logic [CW-1:0]         cnt_bpn;  // periods completed
  logic [CW:0]           bpl_nxt;
  logic [CW:0]           bpn_nxt;
  logic [CCW-1:0]        crd;      // credits
  logic [CCW-1:0]        crd_nxt;
  logic                  start, stop, fire;
  logic                  dat_end, per_end, bst_end;
  logic                  pad_q;    // issued sample is padding

  assign start   = evn.str | (trg & cfg.trg);
  assign stop    = evn.stp | evn.rst;
  assign bpl_nxt = cnt_bpl + 1'b1;
  assign bpn_nxt = cnt_bpn + 1'b1;

  // count as it will be when this cycle's sample is sent
  assign crd_nxt = crd - CCW'(str.valid) + CCW'(str.credit);
  assign fire    = (state != IDLE) && !stop && (crd_nxt != '0);

  assign dat_end = (state == DATA) && (rep == cfg.bdr) && (CW'(adr) == cfg.bdl - 1'b1);
  // data longer than bpl is never cut, the period just ends with it
  assign per_end = (state == PAD || dat_end) && (bpl_nxt >= {1'b0, cfg.bpl});
  assign bst_end = per_end && !cfg.inf && (bpn_nxt >= {1'b0, cfg.bpn});

  //////////////////////////////
  // burst FSM

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      adr     <= '0;
      rep     <= '0;
      cnt_bpl <= '0;
      cnt_bpn <= '0;
    end else if (stop) begin
      state <= IDLE;  // counts kept for status unless rst
      if (evn.rst) begin
        adr     <= '0;
        rep     <= '0;
        cnt_bpl <= '0;
        cnt_bpn <= '0;
      end
    end else if (state == IDLE) begin
      if (start) begin
        state   <= DATA;
        adr     <= '0;
        rep     <= '0;
        cnt_bpl <= '0;
        cnt_bpn <= '0;
      end
    end else if (fire) begin
      if (per_end) begin
        adr     <= '0;
        rep     <= '0;
        cnt_bpn <= bpn_nxt[CW-1:0];
        if (bst_end) begin
          state   <= IDLE;
          cnt_bpl <= bpl_nxt[CW-1:0];  // final count stays readable
        end else begin
          state   <= DATA;
          cnt_bpl <= '0;
        end
      end else begin
        cnt_bpl <= bpl_nxt[CW-1:0];
        if (state == DATA) begin
          if (rep == cfg.bdr) begin
            rep <= '0;
            adr <= adr + 1'b1;
            if (dat_end) state <= PAD;
          end else begin
            rep <= rep + 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////
  // issue, one cycle behind the address

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      str.valid <= 1'b0;
      str.per   <= 1'b0;
      str.lst   <= 1'b0;
      crd       <= CCW'(`LG_SEQ_CREDITS);
    end else begin
      str.valid <= fire;
      str.per   <= fire && (cnt_bpl == '0);
      str.lst   <= fire && bst_end;
      crd       <= crd_nxt;
    end
  end

  always_ff @(posedge bus) begin
    pad_q <= (state == PAD);
  end

  assign str.data = pad_q ? '0 : rd_data;  // table word lands now
  assign rd_addr  = adr;

  // status, str running and stp stopped
  assign sts     = '{rst: 1'b0, str: (state != IDLE), stp: (state == IDLE), swt: 1'b0};
  assign sts_bpl = cnt_bpl;
  assign sts_bpn = cnt_bpn;

  a_valid_credit: assert property (@(posedge bus) disable iff (!arst_n)
    str.valid |-> (crd != '0));
  // sink must not return more than it was sent
  a_credit_max: assert property (@(posedge bus) disable iff (!arst_n)
    crd <= CCW'(`LG_SEQ_CREDITS));

endmodule

`default_nettype wire

/* rtl/lg_out_mask.sv */
// output stage, buffers the stream in a credit FIFO and applies
// mask, polarity and output enables, sends pin words on external credits
`timescale 1ns/10ps
`default_nettype none

`include "lg_params.svh"

module lg_out_mask
  import lg_pkg::*;
(
  input  logic     bus,
  input  logic     arst_n,
  input  lg_cfg_t  cfg,
  lg_stream_if.snk str,
  output logic     pin_valid,
  output sample_t  pin_o,
  output sample_t  pin_e,
  output logic     tro,
  output logic     irq,
  input  logic     pin_credit
);

  localparam int DEPTH = `LG_SEQ_CREDITS;
  localparam int PW    = $clog2(DEPTH);
  localparam int FW    = PW + 1;
  localparam int ECW   = $clog2(`LG_EXT_CREDITS + 1);

  typedef struct packed {
    logic    per;
    logic    lst;
    sample_t data;
  } ent_t;

  ent_t           mem [DEPTH];
  ent_t           head;
  logic [PW-1:0]  wp, rp;       // pointers wrap, depth is a power of 2
  logic [FW-1:0]  fcnt;         // FIFO fill
  logic [ECW-1:0] ecr, ecr_nxt; // external credits
  logic           pop;
  sample_t        o;
  pin_t           pin_q;

  assign ecr_nxt    = ecr - ECW'(pin_valid) + ECW'(pin_credit);
  assign pop        = (fcnt != '0) && (ecr_nxt != '0);
  assign str.credit = pop;  // freed slot goes back to the sequencer

  assign head = mem[rp];
  assign o    = cfg.val ^ (~cfg.msk & head.data);

  always_ff @(posedge bus) begin
    if (str.valid) mem[wp] <= '{per: str.per, lst: str.lst, data: str.data};
    if (pop) pin_q <= '{o: o, e: (cfg.oe1 & o) | (cfg.oe0 & ~o)};
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wp        <= '0;
      rp        <= '0;
      fcnt      <= '0;
      ecr       <= ECW'(`LG_EXT_CREDITS);
      pin_valid <= 1'b0;
      tro       <= 1'b0;
      irq       <= 1'b0;
    end else begin
      if (str.valid) wp <= wp + 1'b1;
      if (pop) rp <= rp + 1'b1;
      fcnt      <= fcnt + FW'(str.valid) - FW'(pop);
      ecr       <= ecr_nxt;
      pin_valid <= pop;
      tro       <= pop & head.per;  // markers travel with their word
      irq       <= pop & head.lst;
    end
  end

  assign pin_o = pin_q.o;
  assign pin_e = pin_q.e;

  // sequencer credits keep the FIFO from filling past its depth
  a_no_overflow: assert property (@(posedge bus) disable iff (!arst_n)
    str.valid |-> ((fcnt < FW'(DEPTH)) || pop));

endmodule

`default_nettype wire

/* rtl/lg_pkg.sv */
// types shared by the logic generator blocks
// import with lg_pkg::* in the module header
`default_nettype none

`include "lg_params.svh"

package lg_pkg;

  // event bits, also the status layout (str running, stp stopped)
  typedef struct packed {
    logic rst;
    logic str;
    logic stp;
    logic swt;
  } evn_t;

  typedef logic [`LG_DW-1:0] sample_t;  // table word and stream payload

  // one pin word
  typedef struct packed {
    sample_t o;  // level
    sample_t e;  // output enable
  } pin_t;

  // configuration written by the CPU
  typedef struct packed {
    logic [`LG_CW-1:0] bdr;  // data repetitions minus one
    logic [`LG_CW-1:0] bdl;  // data length in entries
    logic [`LG_CW-1:0] bpl;  // period length in samples
    logic [`LG_CW-1:0] bpn;  // number of periods
    logic              inf;  // run forever
    logic              trg;  // external trigger mask
    sample_t           oe0;
    sample_t           oe1;
    sample_t           msk;
    sample_t           val;
  } lg_cfg_t;

endpackage

`default_nettype wire

/* rtl/lg_regs.sv */
// bus slave of the logic generator
// holds the configuration, raises event pulses on CTL writes and
// routes accesses with the table bit set to the waveform table
`timescale 1ns/10ps
`default_nettype none

`include "lg_params.svh"

module lg_regs
  import lg_pkg::*;
(
  input  logic                  bus,
  input  logic                  arst_n,
  input  logic [`LG_BAW-1:0]    addr,
  input  logic [`LG_BUS_DW-1:0] wdata,
  input  logic                  wen,
  input  logic                  ren,
  output logic [`LG_BUS_DW-1:0] rdata,
  output logic                  ack,
  output lg_cfg_t               cfg,
  output evn_t                  evn,
  input  evn_t                  sts,
  input  logic [`LG_CW-1:0]     sts_bpl,
  input  logic [`LG_CW-1:0]     sts_bpn,
  output logic                  tbl_wen,
  output logic [`LG_TBL_AW-1:0] tbl_addr,
  output sample_t               tbl_wdata,
  input  sample_t               tbl_rdata
);

  localparam int BDW = `LG_BUS_DW;
  localparam int CW  = `LG_CW;
  localparam int DW  = `LG_DW;
  localparam int EW  = $bits(evn_t);

  logic                   tbl_sel;    // access hits the table window
  logic [`LG_TBL_BIT-1:0] reg_off;
  logic [BDW-1:0]         reg_rdata;
  logic                   rd_tbl;     // last read went to the table

  assign tbl_sel = addr[`LG_TBL_BIT];
  assign reg_off = addr[`LG_TBL_BIT-1:0];

  //////////////////////////////
  // table window

  assign tbl_wen   = wen & tbl_sel;
  assign tbl_addr  = addr[`LG_TBL_AW+1:2];  // one entry per 32 bit word
  assign tbl_wdata = wdata[DW-1:0];

  //////////////////////////////
  // handshake and writes

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ack    <= 1'b0;
      rd_tbl <= 1'b0;
      evn    <= '0;
      cfg    <= '0;
    end else begin
      ack <= wen | ren;  // every access completes
      if (ren) rd_tbl <= tbl_sel;
      // event pulse lasts one cycle
      evn <= (wen && !tbl_sel && reg_off == `LG_REG_CTL) ? evn_t'(wdata[EW-1:0]) : '0;
      if (wen && !tbl_sel) begin
        case (reg_off)
          `LG_REG_TRG:  cfg.trg <= wdata[0];
          `LG_REG_MODE: cfg.inf <= wdata[1];
          `LG_REG_BDR:  cfg.bdr <= wdata[CW-1:0];
          `LG_REG_BDL:  cfg.bdl <= wdata[CW-1:0];
          `LG_REG_BPL:  cfg.bpl <= wdata[CW-1:0];
          `LG_REG_BPN:  cfg.bpn <= wdata[CW-1:0];
          `LG_REG_OE0:  cfg.oe0 <= wdata[DW-1:0];
          `LG_REG_OE1:  cfg.oe1 <= wdata[DW-1:0];
          `LG_REG_MSK:  cfg.msk <= wdata[DW-1:0];
          `LG_REG_VAL:  cfg.val <= wdata[DW-1:0];
          default: ;  // read only or unmapped
        endcase
      end
    end
  end

  //////////////////////////////
  // reads

  always_ff @(posedge bus) begin
    if (ren) begin
      case (reg_off)
        `LG_REG_CTL:  reg_rdata <= BDW'(sts);
        `LG_REG_TRG:  reg_rdata <= BDW'(cfg.trg);
        `LG_REG_MODE: reg_rdata <= BDW'({cfg.inf, 1'b0});
        `LG_REG_BDR:  reg_rdata <= BDW'(cfg.bdr);
        `LG_REG_BDL:  reg_rdata <= BDW'(cfg.bdl);
        `LG_REG_BPL:  reg_rdata <= BDW'(cfg.bpl);
        `LG_REG_BPN:  reg_rdata <= BDW'(cfg.bpn);
        `LG_REG_SBPL: reg_rdata <= BDW'(sts_bpl);
        `LG_REG_SBPN: reg_rdata <= BDW'(sts_bpn);
        `LG_REG_OE0:  reg_rdata <= BDW'(cfg.oe0);
        `LG_REG_OE1:  reg_rdata <= BDW'(cfg.oe1);
        `LG_REG_MSK:  reg_rdata <= BDW'(cfg.msk);
        `LG_REG_VAL:  reg_rdata <= BDW'(cfg.val);
        default:      reg_rdata <= '0;
      endcase
    end
  end

  // table data arrives with ack, same as register data
  assign rdata = rd_tbl ? BDW'(tbl_rdata) : reg_rdata;

  // bus master issues one access type per cycle
  a_no_wen_ren: assert property (@(posedge bus) disable iff (!arst_n) !(wen && ren));

endmodule

`default_nettype wire

/* rtl/lg_stream_if.sv */
// sample stream from the burst sequencer to the output stage
// credit based: src sends only with credits left, snk returns one per pop
`timescale 1ns/10ps
`default_nettype none

interface lg_stream_if
  import lg_pkg::*;
();

  sample_t data;    // sample, zero while padding
  logic    valid;   // one word, no ready
  logic    per;     // first sample of a period
  logic    lst;     // last sample of the last period
  logic    credit;  // one pulse per word leaving the FIFO

  modport src (output data, valid, per, lst, input credit);
  modport snk (input data, valid, per, lst, output credit);

endinterface

`default_nettype wire

/* rtl/lg_table.sv */
// waveform table, one write/read port for the CPU
// and one read port for the burst sequencer, both with one cycle latency
`timescale 1ns/10ps
`default_nettype none

`include "lg_params.svh"

module lg_table
  import lg_pkg::*;
(
  input  logic                  bus,
  input  logic                  cpu_wen,
  input  logic [`LG_TBL_AW-1:0] cpu_addr,
  input  sample_t               cpu_wdata,
  output sample_t               cpu_rdata,
  input  logic [`LG_TBL_AW-1:0] rd_addr,
  output sample_t               rd_data
);

  localparam int DEPTH = 2 ** `LG_TBL_AW;

  sample_t mem [DEPTH];

  // cpu port, read returns old contents on a write
  always_ff @(posedge bus) begin
    if (cpu_wen) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    cpu_rdata <= mem[cpu_addr];
  end

  // sequencer port
  always_ff @(posedge bus) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* rtl/lg_top.sv */
// logic pattern generator top level
// bus for table and registers, pin words out under consumer credits
`timescale 1ns/10ps
`default_nettype none

`include "lg_params.svh"

module lg_top
  import lg_pkg::*;
(
  input  logic                  bus,
  input  logic                  arst_n,
  input  logic [`LG_BAW-1:0]    addr,
  input  logic [`LG_BUS_DW-1:0] wdata,
  input  logic                  wen,
  input  logic                  ren,
  output logic [`LG_BUS_DW-1:0] rdata,
  output logic                  ack,
  input  logic                  trg,
  output logic                  pin_valid,
  output sample_t               pin_o,
  output sample_t               pin_e,
  input  logic                  pin_credit,
  output logic                  tro,
  output logic                  irq
);

  lg_cfg_t               cfg;
  evn_t                  evn, sts;
  logic [`LG_CW-1:0]     sts_bpl, sts_bpn;
  logic                  tbl_wen;
  logic [`LG_TBL_AW-1:0] tbl_addr, rd_addr;
  sample_t               tbl_wdata, tbl_rdata, rd_data;

  lg_stream_if str ();  // sequencer to output stage

  lg_regs u_regs (
    .bus, .arst_n, .addr, .wdata, .wen, .ren, .rdata, .ack,
    .cfg, .evn, .sts, .sts_bpl, .sts_bpn,
    .tbl_wen, .tbl_addr, .tbl_wdata, .tbl_rdata
  );

  lg_table u_table (
    .bus, .cpu_wen (tbl_wen), .cpu_addr (tbl_addr), .cpu_wdata (tbl_wdata),
    .cpu_rdata (tbl_rdata), .rd_addr, .rd_data
  );

  lg_burst_seq u_seq (
    .bus, .arst_n, .cfg, .evn, .trg, .sts, .sts_bpl, .sts_bpn,
    .rd_addr, .rd_data, .str (str.src)
  );

  lg_out_mask u_out (
    .bus, .arst_n, .cfg, .str (str.snk),
    .pin_valid, .pin_o, .pin_e, .tro, .irq, .pin_credit
  );

endmodule

`default_nettype wire

/* verification/tb_lg_top.sv */
// testbench for the logic pattern generator
// bus tasks load registers and table, a consumer model returns pin credits,
// a scoreboard queue built from the burst rules is checked by assertions
`timescale 1ns/10ps
`default_nettype none

`include "lg_params.svh"

module tb_lg_top
  import lg_pkg::*;
();

  localparam int TMO = 2000;  // cycles per wait

  logic                  bus, arst_n, wen, ren, ack, trg;
  logic [`LG_BAW-1:0]    addr;
  logic [`LG_BUS_DW-1:0] wdata, rdata;
  logic                  pin_valid, pin_credit, tro, irq;
  sample_t               pin_o, pin_e;

  logic [17:0] exp_q [$];    // {o, e, tro, irq}
  logic [17:0] exp_cur;      // word now on the pins
  logic        exp_vld;
  int          due_q [$];    // cycles when credits go back
  int          cyc, ext_cnt, rx_cnt, tro_cnt, irq_cnt;
  int          err_cnt, pass_cnt, fail_cnt, err_at_start, ack_wait;
  bit          rnd_dly;      // random credit delay on/off
  logic [7:0]  lfsr = 8'd79;
  sample_t     tbl [16];     // model of the loaded table entries
  int          c_bdr, c_bdl, c_bpl, c_bpn;
  sample_t     c_oe0, c_oe1, c_msk, c_val;

  lg_top dut (.*);

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;  // 8 ns
  end

  //////////////////////////////
  // consumer and scoreboard

  always @(posedge bus) begin
    cyc++;
    #1;
    if (due_q.size() > 0 && due_q[0] <= cyc) begin
      void'(due_q.pop_front());
      pin_credit = 1'b1;
    end else begin
      pin_credit = 1'b0;
    end
  end

  // everything stable at the falling edge
  always @(negedge bus) begin
    if (!arst_n) begin
      ext_cnt = `LG_EXT_CREDITS;
    end else begin
      ext_cnt = ext_cnt - int'(pin_valid) + int'(pin_credit);
      if (pin_valid) begin
        rx_cnt++;
        if (tro) tro_cnt++;
        if (irq) irq_cnt++;
        due_q.push_back(cyc + 1 + (rnd_dly ? rand_bits(2) : 0));  // 0..3 extra
        exp_vld = exp_q.size() > 0;
        if (exp_vld) exp_cur = exp_q.pop_front();
      end
    end
  end

  a_pin_word: assert property (@(posedge bus) disable iff (!arst_n)
    pin_valid |-> (exp_vld && {pin_o, pin_e, tro, irq} == exp_cur))
    else begin
      $display("** Error @ %0t: pin word %h %h tro %b irq %b, expected %h (valid %b)",
               $time, pin_o, pin_e, tro, irq, exp_cur, exp_vld);
      err_cnt++;
    end
  a_marker: assert property (@(posedge bus) disable iff (!arst_n) (tro | irq) |-> pin_valid)
    else begin
      $display("** Error @ %0t: tro or irq without a pin word", $time);
      err_cnt++;
    end
  // a credit returned in the same cycle cannot pay for this word
  a_ext_credit: assert property (@(posedge bus) disable iff (!arst_n)
    pin_valid |-> (ext_cnt - int'(pin_credit) >= 0))
    else begin
      $display("pin word sent at %0t with no external credit left", $time);
      err_cnt++;
    end

  //////////////////////////////
  // helpers

  // galois lfsr stepped once per bit
  function automatic int rand_bits(input int n);
    int v = 0;
    for (int i = 0; i < n; i++) begin
      v    = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hb8) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic end_run(input bit timed_out);
    $display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
    if (!timed_out && fail_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout while waiting for %s", what);
    end_run(1'b1);
  endtask

  task automatic check_eq(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("** Error @ %0t: %s is %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic test_done(input string name);
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL", name);
    end
    err_at_start = err_cnt;
  endtask

  task automatic bus_write(input logic [`LG_BAW-1:0] a, input logic [31:0] d);
    int n = 0;
    @(posedge bus);
    #1 addr = a;
    wdata = d;
    wen = 1'b1;
    @(posedge bus);
    #1 wen = 1'b0;
    while (!ack && n < TMO) begin
      @(posedge bus);
      #1 n++;
    end
    if (!ack) abort_timeout("write ack");
    ack_wait = n;
  endtask

  task automatic bus_read(input logic [`LG_BAW-1:0] a, output logic [31:0] d);
    int n = 0;
    @(posedge bus);
    #1 addr = a;
    ren = 1'b1;
    @(posedge bus);
    #1 ren = 1'b0;
    while (!ack && n < TMO) begin
      @(posedge bus);
      #1 n++;
    end
    if (!ack) abort_timeout("read ack");
    ack_wait = n;
    d = rdata;
  endtask

  // write, read back, and both acks after one cycle
  task automatic reg_check(input logic [`LG_BAW-1:0] a, input int v, input string name);
    logic [31:0] d;
    bus_write(a, v);
    check_eq({name, " write ack wait"}, ack_wait, 0);
    bus_read(a, d);
    check_eq({name, " read ack wait"}, ack_wait, 0);
    check_eq(name, d, v);
  endtask

  task automatic set_burst(input int bdr, bdl, bpl, bpn, input bit inf);
    c_bdr = bdr;
    c_bdl = bdl;
    c_bpl = bpl;
    c_bpn = bpn;
    bus_write(`LG_REG_BDR, bdr);
    bus_write(`LG_REG_BDL, bdl);
    bus_write(`LG_REG_BPL, bpl);
    bus_write(`LG_REG_BPN, bpn);
    bus_write(`LG_REG_MODE, {inf, 1'b0});
  endtask

  // scoreboard from the burst rules
  // a period lasts bpl samples or the whole data if that is longer
  task automatic expect_burst(input int nper, input bit with_irq);
    int      dlen, plen;
    sample_t d, o, e;
    dlen = c_bdl * (c_bdr + 1);
    plen = (dlen < c_bpl) ? c_bpl : dlen;
    for (int p = 0; p < nper; p++) begin
      for (int s = 0; s < plen; s++) begin
        d = (s < dlen) ? tbl[s / (c_bdr + 1)] : '0;  // zero padding
        for (int b = 0; b < `LG_DW; b++) begin
          o[b] = c_msk[b] ? c_val[b] : (c_val[b] ^ d[b]);  // masked bits show polarity only
          e[b] = o[b] ? c_oe1[b] : c_oe0[b];
        end
        exp_q.push_back({o, e, s == 0, with_irq && p == nper - 1 && s == plen - 1});
      end
    end
  endtask

  task automatic wait_irq(input int target);
    int n = 0;
    while (irq_cnt < target && n < TMO) begin
      @(posedge bus);
      #1 n++;
    end
    if (irq_cnt < target) abort_timeout("irq");
  endtask

  task automatic wait_rx(input int target);
    int n = 0;
    while (rx_cnt < target && n < TMO) begin
      @(posedge bus);
      #1 n++;
    end
    if (rx_cnt < target) abort_timeout("pin words");
  endtask

  // no credits owed and the pins idle for a while
  task automatic wait_quiet();
    int n = 0;
    int idle = 0;
    while (idle < 12 && n < TMO) begin
      @(posedge bus);
      #1 n++;
      idle = (pin_valid || due_q.size() > 0) ? 0 : idle + 1;
    end
    if (idle < 12) abort_timeout("pins to go idle");
  endtask

  //////////////////////////////
  // stimulus

  initial begin
    logic [31:0] d;
    int          rx0, t0;
    arst_n = 1'b0;
    addr = '0;
    wdata = '0;
    wen = 1'b0;
    ren = 1'b0;
    trg = 1'b0;
    pin_credit = 1'b0;
    repeat (8) @(posedge bus);
    #1 arst_n = 1'b1;

    // test 1 register map
    check_eq("ack after reset", ack, 0);
    check_eq("pin_valid after reset", pin_valid, 0);
    check_eq("markers after reset", {tro, irq}, 0);
    reg_check(`LG_REG_TRG, 1, "TRG");
    reg_check(`LG_REG_MODE, 2, "MODE");
    reg_check(`LG_REG_BDR, 'h1234, "BDR");
    reg_check(`LG_REG_BDL, 'h00ab, "BDL");
    reg_check(`LG_REG_BPL, 'h5a5a, "BPL");
    reg_check(`LG_REG_BPN, 'h0f0f, "BPN");
    reg_check(`LG_REG_OE0, 'h3c, "OE0");
    reg_check(`LG_REG_OE1, 'hc3, "OE1");
    reg_check(`LG_REG_MSK, 'h81, "MSK");
    reg_check(`LG_REG_VAL, 'h7e, "VAL");
    bus_write(`LG_REG_TRG, 0);
    bus_write(`LG_REG_MODE, 0);
    test_done("test 1 register readback");

    // test 2 table window
    for (int i = 0; i < 16; i++) begin
      tbl[i] = sample_t'(rand_bits(`LG_DW));
      bus_write(12'h800 | (i << 2), tbl[i]);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(12'h800 | (i << 2), d);
      check_eq($sformatf("table entry %0d", i), d, tbl[i]);
    end
    test_done("test 2 table readback");

    // test 3 software start with reps and padding
    c_oe0 = 8'h33;
    c_oe1 = 8'hcc;
    c_msk = 8'h0f;
    c_val = 8'ha5;
    bus_write(`LG_REG_OE0, c_oe0);
    bus_write(`LG_REG_OE1, c_oe1);
    bus_write(`LG_REG_MSK, c_msk);
    bus_write(`LG_REG_VAL, c_val);
    set_burst(1, 3, 10, 1, 1'b0);
    expect_burst(c_bpn, 1'b1);
    rx0 = rx_cnt;
    bus_write(`LG_REG_CTL, 'h4);  // str event
    wait_irq(1);
    wait_quiet();
    check_eq("test 3 words", rx_cnt - rx0, 10);
    check_eq("test 3 irq count", irq_cnt, 1);
    check_eq("test 3 words left", exp_q.size(), 0);
    test_done("test 3 single burst");

    // test 4 external trigger over three periods
    set_burst(0, 4, 6, 3, 1'b0);
    expect_burst(c_bpn, 1'b1);
    rx0 = rx_cnt;
    t0 = tro_cnt;
    bus_write(`LG_REG_TRG, 1);
    @(posedge bus);
    #1 trg = 1'b1;
    @(posedge bus);
    #1 trg = 1'b0;
    bus_write(`LG_REG_TRG, 0);
    wait_irq(2);
    wait_quiet();
    check_eq("test 4 words", rx_cnt - rx0, 18);
    check_eq("test 4 tro count", tro_cnt - t0, 3);
    check_eq("test 4 irq count", irq_cnt, 2);
    bus_read(`LG_REG_SBPL, d);
    check_eq("SBPL", d, 6);
    bus_read(`LG_REG_SBPN, d);
    check_eq("SBPN", d, 3);
    bus_read(`LG_REG_CTL, d);
    check_eq("status after burst", d, 'h2);  // stp set while stopped
    test_done("test 4 triggered burst");

    // test 5 consumer credits late by 0..3 cycles
    rnd_dly = 1'b1;
    set_burst(2, 5, 20, 2, 1'b0);
    expect_burst(c_bpn, 1'b1);
    rx0 = rx_cnt;
    bus_write(`LG_REG_CTL, 'h4);
    wait_irq(3);
    wait_quiet();
    rnd_dly = 1'b0;
    check_eq("test 5 words", rx_cnt - rx0, 40);
    check_eq("test 5 words left", exp_q.size(), 0);
    test_done("test 5 random credit delay");

    // test 6 infinite mode ended by stop
    set_burst(0, 3, 5, 1, 1'b1);
    expect_burst(8, 1'b0);  // more than will be sent
    rx0 = rx_cnt;
    bus_write(`LG_REG_CTL, 'h4);
    wait_rx(rx0 + 12);
    bus_write(`LG_REG_CTL, 'h2);  // stp event
    wait_quiet();
    assert (rx_cnt - rx0 < 40) else begin
      $display("infinite burst did not stop after the stop event");
      err_cnt++;
    end
    check_eq("test 6 irq count", irq_cnt, 3);
    bus_read(`LG_REG_CTL, d);
    check_eq("status after stop", d, 'h2);
    exp_q.delete();
    test_done("test 6 infinite and stop");

    end_run(1'b0);
  end

endmodule

`default_nettype wire
